// File: lsq_pkg.sv
/*
 * Load/store queue shared definitions
 * width, depth and funct3 constants
 * request, response, write-back and fault types
 */

package lsq_pkg;

    // ------------------
    // sizes
    // ------------------
    localparam int LSQ_XLEN       = 32;
    localparam int LSQ_DEPTH_LOG2 = 2;
    localparam int LSQ_REGD_W     = 5;
    localparam int LSQ_ALIGN_W    = 2;

    // ------------------
    // funct3 codes
    // ------------------
    // bits 1:0 carry the access size, bit 2 marks unsigned loads
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // ------------------
    // request side
    // ------------------
    // load view of the payload word
    typedef struct packed {
        logic [LSQ_XLEN-LSQ_REGD_W-1:0] pad;
        logic [LSQ_REGD_W-1:0]          regd;
    } lsq_ldview_t;

    // payload is store data or the load destination
    typedef union packed {
        logic [LSQ_XLEN-1:0] sdata;
        lsq_ldview_t         ld;
    } lsq_payload_u;

    typedef struct packed {
        logic [1:0]            hpl;
        logic [2:0]            funct3;
        logic [LSQ_REGD_W-1:0] regd;
        logic [LSQ_XLEN-1:0]   rs2_data;
        logic [LSQ_XLEN-1:0]   addr;
    } lsq_exs_t;

    // one request fifo entry
    typedef struct packed {
        logic [LSQ_XLEN-1:0] addr;
        lsq_payload_u        payload;
        logic [2:0]          funct3;
        logic [1:0]          hpl;
        logic                is_store;
    } lsq_req_t;

    // per-load bookkeeping while the access is in flight
    typedef struct packed {
        logic [LSQ_ALIGN_W-1:0] align;
        logic [LSQ_REGD_W-1:0]  regd;
        logic [2:0]             funct3;
    } lsq_rsp_ctrl_t;

    // ------------------
    // data port
    // ------------------
    typedef struct packed {
        logic [1:0]          size;
        logic                write;
        logic [1:0]          hpl;
        logic [LSQ_XLEN-1:0] addr;
        logic [LSQ_XLEN-1:0] data;
    } lsq_dreq_t;

    typedef struct packed {
        logic                rerr;
        logic                werr;
        logic [LSQ_XLEN-1:0] data;
    } lsq_drsp_t;

    // ------------------
    // write-back and faults
    // ------------------
    typedef struct packed {
        logic [LSQ_REGD_W-1:0] addr;
        logic [LSQ_XLEN-1:0]   data;
    } lsq_wb_t;

    typedef struct packed {
        logic                laf;
        logic                saf;
        logic [LSQ_XLEN-1:0] rspdata;
    } lsq_fault_t;

    // fifo widths
    localparam int LSQ_REQ_W      = $bits(lsq_req_t);
    localparam int LSQ_RSP_CTRL_W = $bits(lsq_rsp_ctrl_t);

endpackage

// File: lsq_fifo.sv
/*
 * Synchronous FIFO, registered write, head read path
 * depth of 2^LSQ_DEPTH_LOG2 entries
 */

`timescale 1ns/100ps

module lsq_fifo #(
    parameter int WIDTH = 32
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    // write port
    input  logic             wr_i,
    input  logic [WIDTH-1:0] din_i,
    // read port
    input  logic             rd_i,
    output logic [WIDTH-1:0] dout_o,
    // status
    output logic             empty_o,
    output logic             full_o
);

    localparam int AW    = lsq_pkg::LSQ_DEPTH_LOG2;
    localparam int DEPTH = 1 << AW;

    // entry storage
    logic [WIDTH-1:0] mem [DEPTH];

    // pointers carry an extra wrap bit
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    logic do_wr;
    logic do_rd;

    // ------------------
    // status
    // ------------------
    assign empty_o = (wr_ptr == rd_ptr);
    // same index, opposite wrap bit
    assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) &&
                     (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // ignore writes when full and reads when empty
    assign do_wr = wr_i & ~full_o;
    assign do_rd = rd_i & ~empty_o;

    // ------------------
    // pointers
    // ------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ------------------
    // storage
    // ------------------
    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[wr_ptr[AW-1:0]] <= din_i;
        end
    end

    // head entry straight from the registers
    assign dout_o = mem[rd_ptr[AW-1:0]];

endmodule

// File: lsq_req_format.sv
/*
 * Request formatter
 * store data replication and payload packing
 */

`timescale 1ns/100ps

module lsq_req_format (
    input  logic               lq_wr_i,
    input  logic               sq_wr_i,
    input  lsq_pkg::lsq_exs_t  exs_i,
    output logic               wr_o,
    output lsq_pkg::lsq_req_t  entry_o
);

    logic [lsq_pkg::LSQ_XLEN-1:0] sdata;

    assign wr_o = lq_wr_i | sq_wr_i;

    // byte and halfword stores are spread over the whole word
    always_comb begin
        case (exs_i.funct3)
            lsq_pkg::F3_LB: sdata = {4{exs_i.rs2_data[7:0]}};
            lsq_pkg::F3_LH: sdata = {2{exs_i.rs2_data[15:0]}};
            default:        sdata = exs_i.rs2_data;
        endcase
    end

    always_comb begin
        entry_o.addr     = exs_i.addr;
        entry_o.funct3   = exs_i.funct3;
        entry_o.hpl      = exs_i.hpl;
        entry_o.is_store = sq_wr_i;
        if (sq_wr_i) begin
            entry_o.payload.sdata = sdata;
        end else begin
            // loads only need the destination register
            entry_o.payload.ld.pad  = '0;
            entry_o.payload.ld.regd = exs_i.regd;
        end
    end

endmodule

// File: lsq_rsp_format.sv
/*
 * Response formatter
 * right-justifies load data by byte alignment
 * and sign- or zero-extends it by funct3
 */

`timescale 1ns/100ps

module lsq_rsp_format (
    input  lsq_pkg::lsq_rsp_ctrl_t        ctrl_i,
    input  logic [lsq_pkg::LSQ_XLEN-1:0]  data_i,
    output lsq_pkg::lsq_wb_t              wb_o
);

    localparam int XLEN = lsq_pkg::LSQ_XLEN;

    logic [XLEN-1:0] justified;
    logic [XLEN-1:0] extended;

    // ------------------
    // alignment
    // ------------------
    // shift by whole bytes, zeros come in from the top
    assign justified = data_i >> {ctrl_i.align, 3'b000};

    // ------------------
    // extension
    // ------------------
    always_comb begin
        case (ctrl_i.funct3)
            lsq_pkg::F3_LB: begin
                extended = {{(XLEN-8){justified[7]}}, justified[7:0]};
            end
            lsq_pkg::F3_LH: begin
                extended = {{(XLEN-16){justified[15]}}, justified[15:0]};
            end
            lsq_pkg::F3_LBU: begin
                extended = {{(XLEN-8){1'b0}}, justified[7:0]};
            end
            lsq_pkg::F3_LHU: begin
                extended = {{(XLEN-16){1'b0}}, justified[15:0]};
            end
            lsq_pkg::F3_LW: begin
                extended = justified;
            end
            default: begin
                // no wider loads on rv32, pass the word on
                extended = justified;
            end
        endcase
    end

    // ------------------
    // write-back word
    // ------------------
    always_comb begin
        wb_o.addr = ctrl_i.regd;
        wb_o.data = extended;
    end

endmodule

// File: lsq_queue.sv
/*
 * Load/store queue top level
 * request fifo, response control and data fifos,
 * request and response formatters, data port glue
 */

`timescale 1ns/100ps

module lsq_queue (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    // execution stage
    input  logic                    lq_wr_i,
    input  logic                    sq_wr_i,
    input  lsq_pkg::lsq_exs_t       exs_i,
    output logic                    exs_full_o,
    output logic                    exs_empty_o,
    // data port request
    output logic                    dreq_valid_o,
    input  logic                    dreq_ready_i,
    output lsq_pkg::lsq_dreq_t      dreq_o,
    // data port response
    input  logic                    drsp_valid_i,
    output logic                    drsp_ready_o,
    input  lsq_pkg::lsq_drsp_t      drsp_i,
    // write-back and imprecise faults
    output logic                    wb_valid_o,
    output lsq_pkg::lsq_wb_t        wb_o,
    output lsq_pkg::lsq_fault_t     fault_o
);

    // request path
    logic                         req_wr;
    lsq_pkg::lsq_req_t            req_entry;
    lsq_pkg::lsq_req_t            req_head;
    logic                         req_empty;
    logic                         dreq_xfer;
    // response control
    lsq_pkg::lsq_rsp_ctrl_t       ctrl_entry;
    lsq_pkg::lsq_rsp_ctrl_t       ctrl_head;
    logic                         ctrl_empty;
    logic                         ctrl_full;
    // response data
    logic                         data_wr;
    logic [lsq_pkg::LSQ_XLEN-1:0] data_entry;
    logic [lsq_pkg::LSQ_XLEN-1:0] data_head;
    logic                         data_empty;
    logic                         data_full;

    // ------------------
    // request path
    // ------------------
    lsq_req_format u_req_format (
        .lq_wr_i  (lq_wr_i),
        .sq_wr_i  (sq_wr_i),
        .exs_i    (exs_i),
        .wr_o     (req_wr),
        .entry_o  (req_entry)
    );

    lsq_fifo #(
        .WIDTH    (lsq_pkg::LSQ_REQ_W)
    ) u_req_fifo (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wr_i     (req_wr),
        .din_i    (req_entry),
        .rd_i     (dreq_xfer),
        .dout_o   (req_head),
        .empty_o  (req_empty),
        .full_o   (exs_full_o)
    );

    // hold the request back while there is no room to track a load
    assign dreq_valid_o = ~req_empty & ~ctrl_full;
    assign dreq_xfer    = dreq_valid_o & dreq_ready_i;

    always_comb begin
        dreq_o.size  = req_head.funct3[1:0];
        dreq_o.write = req_head.is_store;
        dreq_o.hpl   = req_head.hpl;
        dreq_o.addr  = req_head.addr;
        dreq_o.data  = req_head.payload.sdata;
    end

    assign exs_empty_o = req_empty & ctrl_empty;

    // ------------------
    // response control
    // ------------------
    always_comb begin
        ctrl_entry.align  = req_head.addr[lsq_pkg::LSQ_ALIGN_W-1:0];
        ctrl_entry.regd   = req_head.payload.ld.regd;
        ctrl_entry.funct3 = req_head.funct3;
    end

    // only loads get a response, so only loads are tracked
    lsq_fifo #(
        .WIDTH    (lsq_pkg::LSQ_RSP_CTRL_W)
    ) u_rsp_ctrl_fifo (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wr_i     (dreq_xfer & ~req_head.is_store),
        .din_i    (ctrl_entry),
        .rd_i     (wb_valid_o),
        .dout_o   (ctrl_head),
        .empty_o  (ctrl_empty),
        .full_o   (ctrl_full)
    );

    // ------------------
    // response data
    // ------------------
    // store errors never need data space
    assign drsp_ready_o = drsp_valid_i & (~data_full | drsp_i.werr);
    assign data_wr      = drsp_ready_o & ~drsp_i.werr;
    // failed load writes zero
    assign data_entry   = drsp_i.rerr ? '0 : drsp_i.data;

    lsq_fifo #(
        .WIDTH    (lsq_pkg::LSQ_XLEN)
    ) u_rsp_data_fifo (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wr_i     (data_wr),
        .din_i    (data_entry),
        .rd_i     (wb_valid_o),
        .dout_o   (data_head),
        .empty_o  (data_empty),
        .full_o   (data_full)
    );

    // ------------------
    // write-back
    // ------------------
    assign wb_valid_o = ~data_empty;

    lsq_rsp_format u_rsp_format (
        .ctrl_i   (ctrl_head),
        .data_i   (data_head),
        .wb_o     (wb_o)
    );

    // one pulse per erroring response
    always_comb begin
        fault_o.laf     = drsp_ready_o & drsp_i.rerr;
        fault_o.saf     = drsp_ready_o & drsp_i.werr;
        fault_o.rspdata = drsp_i.data;
    end

endmodule

// File: tb_lsq_mem.sv
/*
 * Testbench data memory for the load/store queue
 * 64 words, random ready stalls, 1 to 3 cycle response latency
 * read and write errors in a fault range at the top
 */

`timescale 1ns/100ps

module tb_lsq_mem (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                hold_i,
    // request channel
    input  logic                dreq_valid_i,
    output logic                dreq_ready_o,
    input  lsq_pkg::lsq_dreq_t  dreq_i,
    // response channel
    output logic                drsp_valid_o,
    input  logic                drsp_ready_i,
    output lsq_pkg::lsq_drsp_t  drsp_o
);

    localparam int         WORDS      = 64;
    localparam logic [7:0] FAULT_BASE = 8'he0;

    logic [31:0]        mem [WORDS];
    lsq_pkg::lsq_drsp_t rsp_q [$];
    int                 due_q [$];
    int                 cycle     = 0;
    logic               loaded    = 1'b0;
    logic               rdy_rand  = 1'b0;
    logic               rsp_valid = 1'b0;
    lsq_pkg::lsq_drsp_t rsp_word  = '0;

    assign dreq_ready_o = rdy_rand & ~hold_i;
    assign drsp_valid_o = rsp_valid;
    assign drsp_o       = rsp_word;

    initial begin
        void'($urandom(32'h8b92afcf));
    end

    // byte lanes touched by an access
    function automatic logic [3:0] lane_mask(input logic [1:0] size, input logic [1:0] low);
        case (size)
            2'd0:    lane_mask = 4'b0001 << low;
            2'd1:    lane_mask = low[1] ? 4'b1100 : 4'b0011;
            default: lane_mask = 4'b1111;
        endcase
    endfunction

    task automatic accept_request();
        logic [5:0]         idx;
        logic [3:0]         be;
        logic               fault;
        lsq_pkg::lsq_drsp_t rsp;
        idx   = dreq_i.addr[7:2];
        fault = (dreq_i.addr[7:0] >= FAULT_BASE);
        be    = lane_mask(dreq_i.size, dreq_i.addr[1:0]);
        rsp   = '0;
        // error responses carry the address as data
        if (dreq_i.write && !fault) begin
            for (int k = 0; k < 4; k++) begin
                if (be[k]) begin
                    mem[idx][{k[1:0], 3'b000} +: 8] = dreq_i.data[{k[1:0], 3'b000} +: 8];
                end
            end
        end else begin
            rsp.werr = dreq_i.write;
            rsp.rerr = ~dreq_i.write & fault;
            rsp.data = fault ? dreq_i.addr : mem[idx];
            rsp_q.push_back(rsp);
            due_q.push_back(cycle + int'($urandom_range(3, 1)));
        end
    endtask

    // --------------------
    // accept side
    // --------------------
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            if (!loaded) begin
                for (int i = 0; i < WORDS; i++) begin
                    mem[i] = $urandom;
                end
                loaded = 1'b1;
            end
            rsp_q.delete();
            due_q.delete();
            cycle = 0;
        end else begin
            cycle = cycle + 1;
            if (drsp_valid_o && drsp_ready_i) begin
                void'(rsp_q.pop_front());
                void'(due_q.pop_front());
            end
            if (dreq_valid_i && dreq_ready_o) begin
                accept_request();
            end
        end
    end

    // --------------------
    // drive side
    // --------------------
    always @(negedge clk_i) begin
        rdy_rand <= ($urandom_range(3, 0) != 0);
        if (rst_n_i && rsp_q.size() != 0 && due_q[0] <= cycle) begin
            rsp_valid <= 1'b1;
            rsp_word  <= rsp_q[0];
        end else begin
            rsp_valid <= 1'b0;
            rsp_word  <= '0;
        end
    end

endmodule

// File: tb_lsq.sv
/*
 * Testbench top for the load/store queue
 * clock and reset, stimulus table, reference memory,
 * compare tasks, watchdog and closing report
 */

`timescale 1ns/100ps

module tb_lsq;

    typedef struct packed {
        logic        store;
        logic [2:0]  funct3;
        logic [31:0] addr;
        logic [31:0] rs2;
        logic [4:0]  regd;
        logic [1:0]  hpl;
        logic        err;
        logic        hold;
    } row_t;

    logic                clk;
    logic                rst_n;
    logic                lq_wr;
    logic                sq_wr;
    lsq_pkg::lsq_exs_t   exs;
    logic                exs_full;
    logic                exs_empty;
    logic                dreq_valid;
    logic                dreq_ready;
    lsq_pkg::lsq_dreq_t  dreq;
    logic                drsp_valid;
    logic                drsp_ready;
    lsq_pkg::lsq_drsp_t  drsp;
    logic                wb_valid;
    lsq_pkg::lsq_wb_t    wb;
    lsq_pkg::lsq_fault_t fault;
    logic                mem_hold;

    row_t                table_q [$];
    logic [31:0]         ref_mem [64];
    lsq_pkg::lsq_dreq_t  exp_dreq [$];
    lsq_pkg::lsq_wb_t    exp_wb [$];
    lsq_pkg::lsq_fault_t exp_fault [$];
    int                  data_cnt  = 0;
    int                  err_wb    = 0;
    int                  err_dreq  = 0;
    int                  err_fault = 0;
    int                  err_misc  = 0;

    lsq_queue u_dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .lq_wr_i      (lq_wr),
        .sq_wr_i      (sq_wr),
        .exs_i        (exs),
        .exs_full_o   (exs_full),
        .exs_empty_o  (exs_empty),
        .dreq_valid_o (dreq_valid),
        .dreq_ready_i (dreq_ready),
        .dreq_o       (dreq),
        .drsp_valid_i (drsp_valid),
        .drsp_ready_o (drsp_ready),
        .drsp_i       (drsp),
        .wb_valid_o   (wb_valid),
        .wb_o         (wb),
        .fault_o      (fault)
    );

    tb_lsq_mem u_mem (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .hold_i       (mem_hold),
        .dreq_valid_i (dreq_valid),
        .dreq_ready_o (dreq_ready),
        .dreq_i       (dreq),
        .drsp_valid_o (drsp_valid),
        .drsp_ready_i (drsp_ready),
        .drsp_o       (drsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // --------------------
    // stimulus table
    // --------------------
    task automatic add_row(input logic st, input logic [2:0] f3, input logic [31:0] addr,
                           input logic [31:0] rs2, input logic [4:0] regd,
                           input logic [1:0] hpl, input logic err, input logic hold);
        table_q.push_back({st, f3, addr, rs2, regd, hpl, err, hold});
    endtask

    task automatic build_table();
        // loads of each size and alignment
        add_row(1'b0, lsq_pkg::F3_LW,  32'h0000_0000, 32'h0, 5'd1,  2'd0, 1'b0, 1'b0);
        add_row(1'b0, lsq_pkg::F3_LB,  32'h0000_0004, 32'h0, 5'd2,  2'd1, 1'b0, 1'b0);
        add_row(1'b0, lsq_pkg::F3_LB,  32'h0000_0005, 32'h0, 5'd3,  2'd0, 1'b0, 1'b0);
        add_row(1'b0, lsq_pkg::F3_LB,  32'h0000_0006, 32'h0, 5'd4,  2'd0, 1'b0, 1'b0);
        add_row(1'b0, lsq_pkg::F3_LB,  32'h0000_0007, 32'h0, 5'd5,  2'd3, 1'b0, 1'b0);
        add_row(1'b0, lsq_pkg::F3_LBU, 32'h0000_0009, 32'h0, 5'd6,  2'd0, 1'b0, 1'b0);
        add_row(1'b0, lsq_pkg::F3_LBU, 32'h0000_000b, 32'h0, 5'd7,  2'd0, 1'b0, 1'b0);
        add_row(1'b0, lsq_pkg::F3_LH,  32'h0000_0010, 32'h0, 5'd8,  2'd2, 1'b0, 1'b0);
        add_row(1'b0, lsq_pkg::F3_LH,  32'h0000_0012, 32'h0, 5'd9,  2'd0, 1'b0, 1'b0);
        add_row(1'b0, lsq_pkg::F3_LHU, 32'h0000_0014, 32'h0, 5'd10, 2'd0, 1'b0, 1'b0);
        add_row(1'b0, lsq_pkg::F3_LHU, 32'h0000_0016, 32'h0, 5'd11, 2'd0, 1'b0, 1'b0);
        // stores and their read-back
        add_row(1'b1, lsq_pkg::F3_LB,  32'h0000_0021, 32'h1234_56a5, 5'd0, 2'd3, 1'b0, 1'b0);
        add_row(1'b1, lsq_pkg::F3_LH,  32'h0000_0026, 32'h0bad_8123, 5'd0, 2'd1, 1'b0, 1'b0);
        add_row(1'b1, lsq_pkg::F3_LW,  32'h0000_0028, 32'hcafe_f00d, 5'd0, 2'd2, 1'b0, 1'b0);
        add_row(1'b0, lsq_pkg::F3_LBU, 32'h0000_0021, 32'h0, 5'd12, 2'd0, 1'b0, 1'b0);
        add_row(1'b0, lsq_pkg::F3_LH,  32'h0000_0026, 32'h0, 5'd13, 2'd0, 1'b0, 1'b0);
        add_row(1'b0, lsq_pkg::F3_LW,  32'h0000_0028, 32'h0, 5'd14, 2'd0, 1'b0, 1'b0);
        add_row(1'b0, lsq_pkg::F3_LB,  32'h0000_0020, 32'h0, 5'd15, 2'd0, 1'b0, 1'b0);
        // fault range
        add_row(1'b0, lsq_pkg::F3_LW,  32'h0000_00e0, 32'h0, 5'd16, 2'd0, 1'b1, 1'b0);
        add_row(1'b1, lsq_pkg::F3_LW,  32'h0000_00e4, 32'h1111_2222, 5'd0, 2'd1, 1'b1, 1'b0);
        add_row(1'b0, lsq_pkg::F3_LB,  32'h0000_00f1, 32'h0, 5'd17, 2'd0, 1'b1, 1'b0);
        // memory held off while four strobes fill the request fifo
        add_row(1'b0, lsq_pkg::F3_LW,  32'h0000_0030, 32'h0, 5'd18, 2'd0, 1'b0, 1'b1);
        add_row(1'b1, lsq_pkg::F3_LB,  32'h0000_0031, 32'h0000_005a, 5'd0, 2'd0, 1'b0, 1'b1);
        add_row(1'b0, lsq_pkg::F3_LHU, 32'h0000_0032, 32'h0, 5'd19, 2'd0, 1'b0, 1'b1);
        add_row(1'b0, lsq_pkg::F3_LBU, 32'h0000_0031, 32'h0, 5'd20, 2'd0, 1'b0, 1'b1);
        add_row(1'b0, lsq_pkg::F3_LW,  32'h0000_003c, 32'h0, 5'd21, 2'd0, 1'b0, 1'b0);
        add_row(1'b0, lsq_pkg::F3_LW,  32'h0000_0000, 32'h0, 5'd22, 2'd0, 1'b0, 1'b0);
    endtask

    // --------------------
    // expected values
    // --------------------
    function automatic logic [31:0] store_value(input logic [2:0] f3, input logic [31:0] rs2);
        case (f3[1:0])
            2'd0:    store_value = {24'b0, rs2[7:0]} * 32'h0101_0101;
            2'd1:    store_value = {16'b0, rs2[15:0]} * 32'h0001_0001;
            default: store_value = rs2;
        endcase
    endfunction

    function automatic logic [31:0] load_value(input logic [31:0] word, input logic [1:0] low,
                                               input logic [2:0] f3);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[{low, 3'b000} +: 8];
        h = low[1] ? word[31:16] : word[15:0];
        case (f3)
            lsq_pkg::F3_LB:  load_value = {{24{b[7]}}, b};
            lsq_pkg::F3_LBU: load_value = {24'b0, b};
            lsq_pkg::F3_LH:  load_value = {{16{h[15]}}, h};
            lsq_pkg::F3_LHU: load_value = {16'b0, h};
            default:         load_value = word;
        endcase
    endfunction

    task automatic update_ref(input row_t r);
        logic [5:0] idx;
        idx = r.addr[7:2];
        case (r.funct3[1:0])
            2'd0:    ref_mem[idx][{r.addr[1:0], 3'b000} +: 8] = r.rs2[7:0];
            2'd1:    ref_mem[idx][{r.addr[1], 4'b0000} +: 16] = r.rs2[15:0];
            default: ref_mem[idx] = r.rs2;
        endcase
    endtask

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_wb(input lsq_pkg::lsq_wb_t got, input lsq_pkg::lsq_wb_t exp);
        if (got !== exp) begin
            $display("Fail %0t wb_o: got %h expected %h", $time, got, exp);
            err_wb++;
        end
    endtask

    task automatic check_dreq(input lsq_pkg::lsq_dreq_t got, input lsq_pkg::lsq_dreq_t exp);
        lsq_pkg::lsq_dreq_t seen;
        seen = got;
        // data lanes only matter for stores
        if (!exp.write) begin
            seen.data = exp.data;
        end
        if (seen !== exp) begin
            $display("Fail %0t dreq_o: got %h expected %h", $time, got, exp);
            err_dreq++;
        end
    endtask

    task automatic check_fault(input lsq_pkg::lsq_fault_t got, input lsq_pkg::lsq_fault_t exp);
        if (got !== exp) begin
            $display("Fail %0t fault_o: got %h expected %h", $time, got, exp);
            err_fault++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %0t %s: got %b expected %b", $time, name, got, exp);
            err_misc++;
        end
    endtask

    // --------------------
    // drive one row
    // --------------------
    task automatic issue_row(input row_t r);
        lsq_pkg::lsq_dreq_t  d;
        lsq_pkg::lsq_wb_t    w;
        lsq_pkg::lsq_fault_t f;
        mem_hold = r.hold;
        while (exs_full) @(negedge clk);
        d.size  = r.funct3[1:0];
        d.write = r.store;
        d.hpl   = r.hpl;
        d.addr  = r.addr;
        d.data  = r.store ? store_value(r.funct3, r.rs2) : 32'h0;
        exp_dreq.push_back(d);
        if (r.err) begin
            f.laf     = ~r.store;
            f.saf     = r.store;
            f.rspdata = r.addr;
            exp_fault.push_back(f);
        end
        if (!r.store) begin
            w.addr = r.regd;
            w.data = r.err ? 32'h0 : load_value(ref_mem[r.addr[7:2]], r.addr[1:0], r.funct3);
            exp_wb.push_back(w);
        end else if (!r.err) begin
            update_ref(r);
        end
        exs.hpl      = r.hpl;
        exs.funct3   = r.funct3;
        exs.regd     = r.regd;
        exs.rs2_data = r.rs2;
        exs.addr     = r.addr;
        lq_wr        = ~r.store;
        sq_wr        = r.store;
        @(negedge clk);
        lq_wr = 1'b0;
        sq_wr = 1'b0;
    endtask

    // wait until every expected transfer has been seen
    task automatic drain_queue();
        while (exp_wb.size() != 0 || exp_dreq.size() != 0 || exp_fault.size() != 0) begin
            @(negedge clk);
        end
        check_flag("exs_empty_o", exs_empty, 1'b1);
        check_flag("wb_valid_o", wb_valid, 1'b0);
    endtask

    // --------------------
    // monitor
    // --------------------
    always @(posedge clk) begin
        logic rsp_take;
        if (rst_n) begin
            // store errors are taken even when the data fifo has no room
            rsp_take = drsp_valid &&
                       (data_cnt < (1 << lsq_pkg::LSQ_DEPTH_LOG2) || drsp.werr);
            check_flag("drsp_ready_o", drsp_ready, rsp_take);
            check_flag("wb_valid_o", wb_valid, data_cnt != 0);
            if (dreq_valid && dreq_ready) begin
                if (exp_dreq.size() == 0) begin
                    $display("request at %0t with nothing left to issue", $time);
                    err_misc++;
                end else begin
                    check_dreq(dreq, exp_dreq.pop_front());
                end
            end
            if (wb_valid) begin
                if (exp_wb.size() == 0) begin
                    $display("write-back at %0t with no load outstanding", $time);
                    err_misc++;
                end else begin
                    check_wb(wb, exp_wb.pop_front());
                end
            end
            if (fault.laf || fault.saf) begin
                if (exp_fault.size() == 0) begin
                    $display("fault pulse at %0t for an access that should succeed", $time);
                    err_misc++;
                end else begin
                    check_fault(fault, exp_fault.pop_front());
                end
            end
            // one word leaves per write-back, one arrives per accepted load response
            data_cnt = data_cnt - ((data_cnt != 0) ? 1 : 0) +
                       ((rsp_take && !drsp.werr) ? 1 : 0);
        end
    end

    // --------------------
    // main sequence
    // --------------------
    initial begin
        int hold_cnt;
        rst_n    = 1'b0;
        lq_wr    = 1'b0;
        sq_wr    = 1'b0;
        exs      = '0;
        mem_hold = 1'b0;
        hold_cnt = 0;
        build_table();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < 64; i++) begin
            ref_mem[i] = u_mem.mem[i];
        end
        check_flag("exs_empty_o", exs_empty, 1'b1);
        check_flag("exs_full_o", exs_full, 1'b0);
        check_flag("dreq_valid_o", dreq_valid, 1'b0);
        for (int n = 0; n < table_q.size(); n++) begin
            // start a stall run from an idle queue
            if (table_q[n].hold && hold_cnt == 0) begin
                drain_queue();
            end
            issue_row(table_q[n]);
            hold_cnt = table_q[n].hold ? hold_cnt + 1 : 0;
            if (hold_cnt == 4) begin
                check_flag("exs_full_o", exs_full, 1'b1);
            end
        end
        mem_hold = 1'b0;
        drain_queue();
        $display("errors: wb %0d, dreq %0d, fault %0d, other %0d",
                 err_wb, err_dreq, err_fault, err_misc);
        if (err_wb + err_dreq + err_fault + err_misc == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog allows 40 cycles per row after reset
    initial begin
        int limit;
        @(negedge clk);
        limit = 16 + table_q.size() * 40;
        repeat (limit) @(posedge clk);
        $display("watchdog expired before all rows completed");
        $display("errors: wb %0d, dreq %0d, fault %0d, other %0d",
                 err_wb, err_dreq, err_fault, err_misc);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: tb.f
lsq_pkg.sv
lsq_fifo.sv
lsq_req_format.sv
lsq_rsp_format.sv
lsq_queue.sv
tb_lsq_mem.sv
tb_lsq.sv

// File: Makefile
# Verilator build and run of the load/store queue testbench

SRCS := lsq_pkg.sv lsq_fifo.sv lsq_req_format.sv lsq_rsp_format.sv lsq_queue.sv \
        tb_lsq_mem.sv tb_lsq.sv

.PHONY: all run clean

all: obj_dir/Vtb_lsq

obj_dir/Vtb_lsq: $(SRCS) tb.f
	verilator --binary --timing -f tb.f --top-module tb_lsq -Mdir obj_dir -o Vtb_lsq

run: obj_dir/Vtb_lsq
	./obj_dir/Vtb_lsq | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
